//--- common/phold_pkg.sv
package phold_pkg;

   // event and timing widths
   localparam int TIME_WID    = 16;
   localparam int NB_LPID     = 6;
   localparam int NUM_CORE    = 4;
   localparam int NB_COREID   = 2;
   localparam int QUEUE_DEPTH = 16;
   localparam int NB_QCNT     = 5;
   localparam int EXEC_CYCLES = 4;
   localparam int NB_INC      = 4;

   // apb register map, byte offsets
   localparam int APB_AW = 8;
   localparam logic [APB_AW-1:0] REG_CTRL         = 8'h00;
   localparam logic [APB_AW-1:0] REG_SIM_END      = 8'h04;
   localparam logic [APB_AW-1:0] REG_NUM_INIT     = 8'h08;
   localparam logic [APB_AW-1:0] REG_LP_MASK      = 8'h0C;
   localparam logic [APB_AW-1:0] REG_STATUS       = 8'h10;
   localparam logic [APB_AW-1:0] REG_GVT          = 8'h14;
   localparam logic [APB_AW-1:0] REG_TOTAL_EVENTS = 8'h18;
   localparam logic [APB_AW-1:0] REG_TOTAL_CYCLES = 8'h1C;

   // galois lfsr, x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_SEED = 32'h5eed_c0de;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   typedef struct packed {
      logic [NB_LPID-1:0]  lp;
      logic [TIME_WID-1:0] ts;
   } event_t;

   typedef struct packed {
      logic [TIME_WID-1:0] sim_end;
      logic [NB_QCNT-1:0]  num_init;
      logic [NB_LPID-1:0]  lp_mask;
   } run_cfg_t;

   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_INIT    = 2'd1,
      ST_RUNNING = 2'd2,
      ST_DONE    = 2'd3
   } run_state_t;

endpackage

//--- common/event_if.sv
`timescale 1ns/1ns

interface event_if;

   logic                            req_vld;
   phold_pkg::event_t               req_msg;
   logic                            rtn_vld;
   phold_pkg::event_t               rtn_msg;
   logic                            rtn_ack;
   logic                            busy;
   logic [phold_pkg::TIME_WID-1:0]  cur_time;

   // busy is also seen by the dispatcher to find an idle core
   modport dispatch (
      output req_vld, req_msg, rtn_ack,
      input  rtn_vld, rtn_msg, busy
   );

   modport core (
      input  req_vld, req_msg, rtn_ack,
      output rtn_vld, rtn_msg, busy, cur_time
   );

endinterface

//--- source/apb_regs.sv
`timescale 1ns/1ns

module apb_regs (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            psel,
   input  logic                            penable,
   input  logic                            pwrite,
   input  logic [phold_pkg::APB_AW-1:0]    paddr,
   input  logic [31:0]                     pwdata,
   input  phold_pkg::run_state_t           state,
   input  logic [phold_pkg::NB_QCNT-1:0]   q_count,
   input  logic [phold_pkg::TIME_WID-1:0]  gvt,
   input  logic [31:0]                     total_events,
   input  logic [31:0]                     total_cycles,
   output logic [31:0]                     prdata,
   output logic                            pready,
   output logic                            pslverr,
   output phold_pkg::run_cfg_t             cfg,
   output logic                            start
);

   logic access;
   logic unmapped;
   logic cfg_addr;
   logic cfg_locked;
   logic bad_init;
   logic wr_ok;

   assign access     = psel & penable;
   assign cfg_locked = (state == phold_pkg::ST_INIT) || (state == phold_pkg::ST_RUNNING);
   assign cfg_addr   = (paddr == phold_pkg::REG_SIM_END) || (paddr == phold_pkg::REG_NUM_INIT) ||
                       (paddr == phold_pkg::REG_LP_MASK);
   assign bad_init   = (paddr == phold_pkg::REG_NUM_INIT) &&
                       ((pwdata == 32'd0) || (pwdata > phold_pkg::QUEUE_DEPTH));

   // zero wait states
   assign pready  = 1'b1;
   assign pslverr = access && (unmapped || (pwrite && cfg_addr && (cfg_locked || bad_init)));
   assign wr_ok   = access && pwrite && !pslverr;

   // only a run that is not in progress can be started
   assign start = wr_ok && (paddr == phold_pkg::REG_CTRL) && pwdata[0] &&
                  ((state == phold_pkg::ST_IDLE) || (state == phold_pkg::ST_DONE));

   always_comb begin
      prdata   = '0;
      unmapped = 1'b0;
      case (paddr)
         phold_pkg::REG_CTRL:         prdata = '0;
         phold_pkg::REG_SIM_END:      prdata[phold_pkg::TIME_WID-1:0] = cfg.sim_end;
         phold_pkg::REG_NUM_INIT:     prdata[phold_pkg::NB_QCNT-1:0] = cfg.num_init;
         phold_pkg::REG_LP_MASK:      prdata[phold_pkg::NB_LPID-1:0] = cfg.lp_mask;
         phold_pkg::REG_STATUS:       prdata = {19'd0, q_count, 6'd0, state};
         phold_pkg::REG_GVT:          prdata[phold_pkg::TIME_WID-1:0] = gvt;
         phold_pkg::REG_TOTAL_EVENTS: prdata = total_events;
         phold_pkg::REG_TOTAL_CYCLES: prdata = total_cycles;
         default:                     unmapped = 1'b1;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg <= '0;
      end else if (wr_ok) begin
         case (paddr)
            phold_pkg::REG_SIM_END:  cfg.sim_end  <= pwdata[phold_pkg::TIME_WID-1:0];
            phold_pkg::REG_NUM_INIT: cfg.num_init <= pwdata[phold_pkg::NB_QCNT-1:0];
            phold_pkg::REG_LP_MASK:  cfg.lp_mask  <= pwdata[phold_pkg::NB_LPID-1:0];
            default: ;
         endcase
      end
   end

endmodule

//--- source/gvt_stats.sv
`timescale 1ns/1ns

module gvt_stats (
   input  logic                            clk,
   input  logic                            rst_n,
   input  phold_pkg::run_state_t           state,
   input  logic                            start,
   input  phold_pkg::event_t               head,
   input  logic                            empty,
   input  logic                            deq,
   input  logic [phold_pkg::NUM_CORE-1:0]  busy,
   input  logic [phold_pkg::NUM_CORE-1:0][phold_pkg::TIME_WID-1:0] cur_time,
   output logic [phold_pkg::TIME_WID-1:0]  gvt,
   output logic [31:0]                     total_events,
   output logic [31:0]                     total_cycles
);

   logic [phold_pkg::TIME_WID-1:0] min_t;
   logic                           min_vld;

   // lowest timestamp still alive, queued or in flight
   always_comb begin
      min_t   = '1;
      min_vld = !empty;
      if (!empty) begin
         min_t = head.ts;
      end
      for (int i = 0; i < phold_pkg::NUM_CORE; i++) begin
         if (busy[i]) begin
            min_vld = 1'b1;
            if (cur_time[i] < min_t) begin
               min_t = cur_time[i];
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt          <= '0;
         total_events <= '0;
         total_cycles <= '0;
      end else if (start) begin
         gvt          <= '0;
         total_events <= '0;
         total_cycles <= '0;
      end else if (state == phold_pkg::ST_RUNNING) begin
         total_cycles <= total_cycles + 32'd1;
         if (min_vld) begin
            gvt <= min_t;
         end
         if (deq) begin
            total_events <= total_events + 32'd1;
         end
      end
   end

endmodule

//--- event_sched/event_queue.sv
`timescale 1ns/1ns

module event_queue (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           enq,
   input  phold_pkg::event_t              enq_msg,
   input  logic                           deq,
   input  logic                           clear,
   output phold_pkg::event_t              head,
   output logic                           empty,
   output logic [phold_pkg::NB_QCNT-1:0]  count
);

   phold_pkg::event_t                  q [phold_pkg::QUEUE_DEPTH];
   logic [phold_pkg::QUEUE_DEPTH-1:0]  ins;

   // ins[i] set where the new event sits at or ahead of slot i
   // equal timestamps stay in front so ties keep arrival order
   always_comb begin
      for (int i = 0; i < phold_pkg::QUEUE_DEPTH; i++) begin
         ins[i] = (i >= int'(count)) || (q[i].ts > enq_msg.ts);
      end
   end

   always_ff @(posedge clk) begin
      if (enq) begin
         for (int i = 0; i < phold_pkg::QUEUE_DEPTH; i++) begin
            if (ins[i]) begin
               if (i == 0) begin
                  q[i] <= enq_msg;
               end else if (!ins[i-1]) begin
                  q[i] <= enq_msg;
               end else begin
                  q[i] <= q[i-1];
               end
            end
         end
      end else if (deq) begin
         for (int i = 0; i < phold_pkg::QUEUE_DEPTH - 1; i++) begin
            q[i] <= q[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (clear) begin
         count <= '0;
      end else if (enq) begin
         if (int'(count) != phold_pkg::QUEUE_DEPTH) begin
            count <= count + 1'b1;
         end
      end else if (deq && !empty) begin
         count <= count - 1'b1;
      end
   end

   assign head  = q[0];
   assign empty = (count == '0);

endmodule

//--- event_sched/event_dispatch.sv
`timescale 1ns/1ns

module event_dispatch (
   input  logic                            clk,
   input  logic                            rst_n,
   input  phold_pkg::run_cfg_t             cfg,
   input  logic                            start,
   input  logic [phold_pkg::TIME_WID-1:0]  gvt,
   input  phold_pkg::event_t               head,
   input  logic                            empty,
   output phold_pkg::run_state_t           state,
   output logic                            enq,
   output phold_pkg::event_t               enq_msg,
   output logic                            deq,
   output logic                            clear,
   event_if.dispatch                       cores [phold_pkg::NUM_CORE]
);

   logic [phold_pkg::NUM_CORE-1:0]   busy_v;
   logic [phold_pkg::NUM_CORE-1:0]   rtn_vld_v;
   phold_pkg::event_t                rtn_msg_v [phold_pkg::NUM_CORE];
   logic [phold_pkg::NB_COREID-1:0]  rtn_idx;
   logic [phold_pkg::NB_COREID-1:0]  rtn_last;
   logic [phold_pkg::NB_COREID-1:0]  send_idx;
   logic [phold_pkg::NB_COREID-1:0]  send_last;
   logic [phold_pkg::NB_QCNT-1:0]    init_cnt;
   logic                             running;
   logic                             ack;
   logic                             last_init;

   // next requester after the last grant, the last grant itself comes last
   function automatic logic [phold_pkg::NB_COREID-1:0] rr_pick(
      input logic [phold_pkg::NUM_CORE-1:0]  req,
      input logic [phold_pkg::NB_COREID-1:0] last
   );
      logic [phold_pkg::NB_COREID-1:0] idx;
      rr_pick = last;
      for (int i = phold_pkg::NUM_CORE; i >= 1; i--) begin
         idx = last + i[phold_pkg::NB_COREID-1:0];
         if (req[idx]) begin
            rr_pick = idx;
         end
      end
   endfunction

   for (genvar i = 0; i < phold_pkg::NUM_CORE; i++) begin : g_port
      assign busy_v[i]        = cores[i].busy;
      assign rtn_vld_v[i]     = cores[i].rtn_vld;
      assign rtn_msg_v[i]     = cores[i].rtn_msg;
      assign cores[i].req_vld = deq && (send_idx == i);
      assign cores[i].req_msg = head;
      assign cores[i].rtn_ack = ack && (rtn_idx == i);
   end

   assign running  = (state == phold_pkg::ST_RUNNING);
   assign rtn_idx  = rr_pick(rtn_vld_v, rtn_last);
   assign send_idx = rr_pick(~busy_v, send_last);

   // one queue operation per cycle, returns win over dispatch
   assign ack = running && (|rtn_vld_v);
   assign deq = running && !ack && !empty && (head.ts <= cfg.sim_end) && !(&busy_v);
   assign enq = ack || (state == phold_pkg::ST_INIT);

   // initial events all start at time 0
   always_comb begin
      if (state == phold_pkg::ST_INIT) begin
         enq_msg.lp = {1'b0, init_cnt} & cfg.lp_mask;
         enq_msg.ts = '0;
      end else begin
         enq_msg = rtn_msg_v[rtn_idx];
      end
   end

   assign clear     = start;
   assign last_init = ((init_cnt + 1'b1) >= cfg.num_init);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= phold_pkg::ST_IDLE;
         init_cnt  <= '0;
         rtn_last  <= '0;
         send_last <= '0;
      end else begin
         case (state)
            phold_pkg::ST_INIT: begin
               init_cnt <= init_cnt + 1'b1;
               if (last_init) begin
                  state <= phold_pkg::ST_RUNNING;
               end
            end
            phold_pkg::ST_RUNNING: begin
               if (gvt > cfg.sim_end) begin
                  state <= phold_pkg::ST_DONE;
               end
            end
            default: begin
               if (start) begin
                  state    <= phold_pkg::ST_INIT;
                  init_cnt <= '0;
               end
            end
         endcase
         if (ack) begin
            rtn_last <= rtn_idx;
         end
         if (deq) begin
            send_last <= send_idx;
         end
      end
   end

endmodule

//--- event_core/event_core.sv
`timescale 1ns/1ns

module event_core #(
   parameter logic [31:0] SEED = 32'h1
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [phold_pkg::NB_LPID-1:0]  lp_mask,
   event_if.core                          ev
);

   logic [31:0]                                      lfsr;
   logic [$clog2(phold_pkg::EXEC_CYCLES)-1:0]        cnt;
   logic [phold_pkg::TIME_WID-1:0]                   inc;
   logic                                             accept;

   assign accept = ev.req_vld && !ev.busy;

   // random step of 1 to 16 from the bits above the lp id
   assign inc = {{(phold_pkg::TIME_WID - phold_pkg::NB_INC){1'b0}},
                 lfsr[phold_pkg::NB_LPID +: phold_pkg::NB_INC]} + 1'b1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lfsr       <= SEED;
         cnt        <= '0;
         ev.busy    <= 1'b0;
         ev.rtn_vld <= 1'b0;
      end else if (accept) begin
         ev.busy <= 1'b1;
         cnt     <= $bits(cnt)'(phold_pkg::EXEC_CYCLES - 2);
         lfsr    <= {1'b0, lfsr[31:1]} ^ (lfsr[0] ? phold_pkg::LFSR_TAPS : 32'd0);
      end else if (ev.busy) begin
         if (ev.rtn_ack) begin
            ev.busy    <= 1'b0;
            ev.rtn_vld <= 1'b0;
         end else if (!ev.rtn_vld) begin
            // result goes out EXEC_CYCLES after the request
            if (cnt == '0) begin
               ev.rtn_vld <= 1'b1;
            end else begin
               cnt <= cnt - 1'b1;
            end
         end
      end
   end

   // new event is formed at accept and held until acked
   always_ff @(posedge clk) begin
      if (accept) begin
         ev.cur_time   <= ev.req_msg.ts;
         ev.rtn_msg.lp <= lfsr[phold_pkg::NB_LPID-1:0] & lp_mask;
         ev.rtn_msg.ts <= ev.req_msg.ts + inc;
      end
   end

endmodule

//--- source/phold_top.sv
`timescale 1ns/1ns

module phold_top (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [phold_pkg::APB_AW-1:0]  paddr,
   input  logic [31:0]                   pwdata,
   output logic [31:0]                   prdata,
   output logic                          pready,
   output logic                          pslverr
);

   phold_pkg::run_cfg_t    cfg;
   phold_pkg::run_state_t  state;
   phold_pkg::event_t      head;
   phold_pkg::event_t      enq_msg;
   logic                   start;
   logic                   enq;
   logic                   deq;
   logic                   clear;
   logic                   empty;
   logic [phold_pkg::NB_QCNT-1:0]   q_count;
   logic [phold_pkg::TIME_WID-1:0]  gvt;
   logic [31:0]                     total_events;
   logic [31:0]                     total_cycles;
   logic [phold_pkg::NUM_CORE-1:0]                            core_busy;
   logic [phold_pkg::NUM_CORE-1:0][phold_pkg::TIME_WID-1:0]   core_time;

   event_if ev_if [phold_pkg::NUM_CORE] ();

   apb_regs i_apb_regs (
      .clk          (clk),
      .rst_n        (rst_n),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .state        (state),
      .q_count      (q_count),
      .gvt          (gvt),
      .total_events (total_events),
      .total_cycles (total_cycles),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .cfg          (cfg),
      .start        (start)
   );

   event_queue i_event_queue (
      .clk     (clk),
      .rst_n   (rst_n),
      .enq     (enq),
      .enq_msg (enq_msg),
      .deq     (deq),
      .clear   (clear),
      .head    (head),
      .empty   (empty),
      .count   (q_count)
   );

   event_dispatch i_event_dispatch (
      .clk     (clk),
      .rst_n   (rst_n),
      .cfg     (cfg),
      .start   (start),
      .gvt     (gvt),
      .head    (head),
      .empty   (empty),
      .state   (state),
      .enq     (enq),
      .enq_msg (enq_msg),
      .deq     (deq),
      .clear   (clear),
      .cores   (ev_if)
   );

   for (genvar g = 0; g < phold_pkg::NUM_CORE; g++) begin : g_core
      // each core gets the base seed with its index in the top byte
      event_core #(
         .SEED (phold_pkg::LFSR_SEED ^ (32'(g) << 24))
      ) i_event_core (
         .clk     (clk),
         .rst_n   (rst_n),
         .lp_mask (cfg.lp_mask),
         .ev      (ev_if[g])
      );

      assign core_busy[g] = ev_if[g].busy;
      assign core_time[g] = ev_if[g].cur_time;
   end

   gvt_stats i_gvt_stats (
      .clk          (clk),
      .rst_n        (rst_n),
      .state        (state),
      .start        (start),
      .head         (head),
      .empty        (empty),
      .deq          (deq),
      .busy         (core_busy),
      .cur_time     (core_time),
      .gvt          (gvt),
      .total_events (total_events),
      .total_cycles (total_cycles)
   );

endmodule

//--- sim/tb_apb_tasks.svh
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// galois lfsr for the stimulus, x^32 + x^30 + x^26 + x^25 + 1
localparam logic [31:0] RNG_SEED = 32'ha96cda14;
localparam logic [31:0] RNG_TAPS = 32'hA300_0000;

logic [31:0] rng_state;

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int nbits);
   logic [31:0] val;
   val = '0;
   for (int i = 0; i < nbits; i++) begin
      val       = {val[30:0], rng_state[0]};
      rng_state = {1'b0, rng_state[31:1]} ^ (rng_state[0] ? RNG_TAPS : 32'd0);
   end
   return val;
endfunction

// setup phase on one falling edge, access phase on the next
task automatic apb_access(
   input  logic                          write,
   input  logic [phold_pkg::APB_AW-1:0]  addr,
   input  logic [31:0]                   wdata,
   output logic [31:0]                   rdata,
   output logic                          err
);
   @(negedge clk);
   psel    = 1'b1;
   penable = 1'b0;
   pwrite  = write;
   paddr   = addr;
   pwdata  = wdata;
   @(negedge clk);
   penable = 1'b1;
   // sample well away from both clock edges
   #(SAMPLE_DLY);
   rdata = prdata;
   err   = pslverr;
   assert (pready) else begin
      errors++;
      $display("pready was low in an access phase at %0t", $time);
   end
   @(negedge clk);
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic apb_write(
   input  logic [phold_pkg::APB_AW-1:0]  addr,
   input  logic [31:0]                   data,
   output logic                          err
);
   logic [31:0] unused_rd;
   apb_access(1'b1, addr, data, unused_rd, err);
endtask

task automatic apb_read(
   input  logic [phold_pkg::APB_AW-1:0]  addr,
   output logic [31:0]                   data,
   output logic                          err
);
   apb_access(1'b0, addr, 32'd0, data, err);
endtask

`endif

//--- sim/tb_phold.sv
`timescale 1ns/1ns

module tb_phold;

   localparam int CLK_HALF      = 50;
   localparam int SAMPLE_DLY    = CLK_HALF / 2;
   localparam int NUM_RUNS      = 4;
   localparam int MIN_SIM_END   = 100;
   localparam int MAX_SIM_END   = 400;
   localparam int MAX_NUM_INIT  = 16;
   localparam int EXEC_CYCLES   = 4;
   localparam int NUM_CORE      = 4;
   localparam int MAX_INC       = 16;
   localparam int RESTART_BOUND = 8;
   localparam int WATCHDOG_CYCLES =
      NUM_RUNS * (MAX_SIM_END + 1) * MAX_NUM_INIT * (EXEC_CYCLES + 4);

   logic        clk;
   logic        rst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   int          errors;
   int          checks;

   `include "tb_apb_tasks.svh"

   phold_top i_phold_top (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   always #(CLK_HALF) clk = ~clk;

   task automatic check_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual == expected) else begin
         errors++;
         $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_range(input string name, input logic [31:0] lo,
                              input logic [31:0] hi, input logic [31:0] actual);
      checks++;
      assert ((actual >= lo) && (actual <= hi)) else begin
         errors++;
         $display("FAILED %s: expected %0d..%0d, actual %0d", name, lo, hi, actual);
      end
   endtask

   task automatic write_expect(input string name, input logic [7:0] addr,
                               input logic [31:0] data, input logic exp_err);
      logic err;
      apb_write(addr, data, err);
      check_equal({name, " pslverr"}, 32'(exp_err), 32'(err));
   endtask

   task automatic read_expect(input string name, input logic [7:0] addr,
                              input logic [31:0] expected);
      logic [31:0] rd;
      logic        err;
      apb_read(addr, rd, err);
      check_equal({name, " pslverr"}, 32'd0, 32'(err));
      check_equal(name, expected, rd);
   endtask

   task automatic read_value(input logic [7:0] addr, output logic [31:0] data);
      logic err;
      apb_read(addr, data, err);
      check_equal("register read pslverr", 32'd0, 32'(err));
   endtask

   task automatic check_config();
      logic [31:0] rd;
      logic [31:0] end_val;
      logic [31:0] init_val;
      logic        err;
      end_val  = rand_bits(16);
      init_val = 32'd1 + rand_bits(4);
      write_expect("sim_end write", phold_pkg::REG_SIM_END, end_val, 1'b0);
      read_expect("sim_end readback", phold_pkg::REG_SIM_END, end_val);
      write_expect("num_init write", phold_pkg::REG_NUM_INIT, init_val, 1'b0);
      write_expect("lp_mask write", phold_pkg::REG_LP_MASK, 32'h2a, 1'b0);
      read_expect("lp_mask readback", phold_pkg::REG_LP_MASK, 32'h2a);
      // rejected writes leave num_init alone
      write_expect("num_init zero", phold_pkg::REG_NUM_INIT, 32'd0, 1'b1);
      write_expect("num_init 17", phold_pkg::REG_NUM_INIT, 32'd17, 1'b1);
      read_expect("num_init readback", phold_pkg::REG_NUM_INIT, init_val);
      write_expect("unmapped write", 8'h20, 32'h1234, 1'b1);
      apb_read(8'h24, rd, err);
      check_equal("unmapped read pslverr", 32'd1, 32'(err));
   endtask

   task automatic run_once();
      logic [31:0] sim_end;
      logic [31:0] num_init;
      logic [31:0] lp_mask;
      logic [31:0] rd;
      logic [31:0] gvt;
      logic [31:0] last_gvt;
      logic [31:0] events;
      logic [31:0] cycles;
      logic        done;
      sim_end  = MIN_SIM_END + (rand_bits(9) % (MAX_SIM_END - MIN_SIM_END + 1));
      num_init = 32'd1 + rand_bits(4);
      lp_mask  = rand_bits(6);
      write_expect("sim_end write", phold_pkg::REG_SIM_END, sim_end, 1'b0);
      write_expect("num_init write", phold_pkg::REG_NUM_INIT, num_init, 1'b0);
      write_expect("lp_mask write", phold_pkg::REG_LP_MASK, lp_mask, 1'b0);
      read_expect("num_init readback", phold_pkg::REG_NUM_INIT, num_init);
      write_expect("start write", phold_pkg::REG_CTRL, 32'd1, 1'b0);
      // counters restart from zero and only a few cycles have passed since
      read_value(phold_pkg::REG_TOTAL_EVENTS, rd);
      check_range("total_events after start", 0, RESTART_BOUND, rd);
      read_value(phold_pkg::REG_TOTAL_CYCLES, rd);
      check_range("total_cycles after start", 0, RESTART_BOUND, rd);
      do begin
         read_value(phold_pkg::REG_STATUS, rd);
      end while (rd[1:0] == phold_pkg::ST_INIT);
      check_equal("state after init", 32'(phold_pkg::ST_RUNNING), 32'(rd[1:0]));
      write_expect("sim_end write while running", phold_pkg::REG_SIM_END, sim_end + 1, 1'b1);
      write_expect("lp_mask write while running", phold_pkg::REG_LP_MASK, ~lp_mask, 1'b1);
      read_expect("sim_end kept while running", phold_pkg::REG_SIM_END, sim_end);
      read_expect("lp_mask kept while running", phold_pkg::REG_LP_MASK, lp_mask);
      last_gvt = 0;
      done     = 1'b0;
      while (!done) begin
         read_value(phold_pkg::REG_STATUS, rd);
         done = (rd[1:0] == phold_pkg::ST_DONE);
         if (!done) begin
            check_equal("status during run", 32'(phold_pkg::ST_RUNNING), 32'(rd[1:0]));
         end
         read_value(phold_pkg::REG_GVT, gvt);
         check_range("gvt never decreases", last_gvt, 32'hffff, gvt);
         last_gvt = gvt;
      end
      read_value(phold_pkg::REG_STATUS, rd);
      check_equal("queue count at done", num_init, 32'(rd[12:8]));
      read_value(phold_pkg::REG_GVT, gvt);
      check_range("final gvt", sim_end + 1, sim_end + MAX_INC, gvt);
      read_value(phold_pkg::REG_TOTAL_EVENTS, events);
      check_range("total_events", num_init * ((sim_end + MAX_INC) / MAX_INC),
                  num_init * (sim_end + 1), events);
      read_value(phold_pkg::REG_TOTAL_CYCLES, cycles);
      check_range("total_cycles", events * EXEC_CYCLES / NUM_CORE, 32'hffff_ffff, cycles);
   endtask

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      errors    = 0;
      checks    = 0;
      rng_state = RNG_SEED;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      read_expect("status after reset", phold_pkg::REG_STATUS, 32'd0);
      read_expect("gvt after reset", phold_pkg::REG_GVT, 32'd0);
      read_expect("total_events after reset", phold_pkg::REG_TOTAL_EVENTS, 32'd0);
      read_expect("total_cycles after reset", phold_pkg::REG_TOTAL_CYCLES, 32'd0);
      check_config();
      for (int r = 0; r < NUM_RUNS; r++) begin
         run_once();
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // bound on the whole run well above its expected length
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired before all runs finished, %0d errors so far", errors);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+sim
common/phold_pkg.sv
common/event_if.sv
source/apb_regs.sv
source/gvt_stats.sv
event_sched/event_queue.sv
event_sched/event_dispatch.sv
event_core/event_core.sv
source/phold_top.sv
sim/tb_phold.sv

//--- Makefile
SIM      = verilator
TOP      = tb_phold
FILELIST = verilog.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) sim/tb_apb_tasks.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) -o V$(TOP)

# pass only when the pass message shows up in the output
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
